/* src/defines.sv */
package defines;

	localparam int XLEN = 32;
	localparam int REG_IDX_W = 5;

	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
	localparam logic [XLEN-1:0] PC_STEP = 32'd4;	// one instruction
	localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;	// addi x0, x0, 0

	typedef logic [XLEN-1:0] data_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// only the control flow opcodes matter here
	typedef enum logic [6:0] {
		OTHER = 7'b0010011,	// op-imm, stands in for the rest
		B = 7'b1100011,
		JALR = 7'b1100111,
		JAL = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		BEQ = 3'b000,
		BNE = 3'b001,
		BLT = 3'b100,
		BGE = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} funct3_t;

	// register view of the word
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t rs2;
		reg_idx_t rs1;
		funct3_t funct3;
		reg_idx_t rd;
		opcode_t opcode;
	} instr_r_t;

	// raw immediate bits, split where the B, J and I formats cut them
	typedef struct packed {
		logic sign;	// bit 31, sign of every format
		logic [5:0] imm_10_5;	// shared by B, J and I
		logic [3:0] imm_4_1;	// J and I, rs2 field in B
		logic imm_20;	// J bit 11, I bit 0
		logic [7:0] imm_19_12;	// J only
		logic [3:0] b_4_1;
		logic b_11;
		opcode_t opcode;
	} instr_imm_t;

	typedef union packed {
		instr_r_t r;
		instr_imm_t imm;
	} instr_t;

	// operand source for the branch compare
	typedef enum logic [1:0] {
		B_RS_SEL = 2'b00,
		B_EX_SEL = 2'b01,
		B_MEM_SEL = 2'b10,
		B_WB_SEL = 2'b11
	} branch_fwd_t;

	// one later stage that may hold a newer value of a register
	typedef struct packed {
		logic we;
		reg_idx_t rd;
		data_t data;
	} stage_src_t;

endpackage

/* src/branch_fwd_unit.sv */
module branch_fwd_unit (
	input defines::instr_t instr,
	input defines::stage_src_t ex_src,
	input defines::stage_src_t mem_src,
	input defines::stage_src_t wb_src,

	output defines::branch_fwd_t fwd_rs1,
	output defines::branch_fwd_t fwd_rs2
);

	// stage writes the register we are about to read
	function automatic logic writes(
		input defines::stage_src_t src,
		input defines::reg_idx_t idx
	);
		return src.we && (src.rd != '0) && (src.rd == idx);
	endfunction

	// youngest writer wins, x0 is never forwarded
	function automatic defines::branch_fwd_t pick(
		input defines::reg_idx_t idx,
		input defines::stage_src_t ex,
		input defines::stage_src_t mem,
		input defines::stage_src_t wb
	);
		defines::branch_fwd_t sel;
		sel = defines::B_RS_SEL;
		if (idx != '0) begin
			if (writes(ex, idx))
				sel = defines::B_EX_SEL;
			else if (writes(mem, idx))
				sel = defines::B_MEM_SEL;
			else if (writes(wb, idx))
				sel = defines::B_WB_SEL;
		end
		return sel;
	endfunction

	assign fwd_rs1 = pick(instr.r.rs1, ex_src, mem_src, wb_src);
	assign fwd_rs2 = pick(instr.r.rs2, ex_src, mem_src, wb_src);	// don't care for jumps

endmodule

/* src/pc_adder.sv */
module pc_adder (
	input defines::instr_t instr,
	input defines::data_t pc,
	input defines::data_t rs1,
	input defines::data_t rs2,
	input defines::data_t ex_data,
	input defines::data_t mem_data,
	input defines::data_t wb_data,
	input defines::branch_fwd_t fwd_rs1,
	input defines::branch_fwd_t fwd_rs2,

	output defines::data_t pc_bj,
	output logic pc_sel,
	output logic branch_taken
);

	defines::opcode_t opcode;
	defines::funct3_t funct3;
	defines::data_t op1;
	defines::data_t op2;
	defines::data_t base;
	defines::data_t imm;
	defines::data_t sum;
	logic eq;
	logic lt;
	logic ltu;
	logic cond;

	function automatic defines::data_t fwd_mux(
		input defines::branch_fwd_t sel,
		input defines::data_t rf,
		input defines::data_t ex,
		input defines::data_t mem,
		input defines::data_t wb
	);
		defines::data_t val;
		case (sel)
			defines::B_EX_SEL: val = ex;
			defines::B_MEM_SEL: val = mem;
			defines::B_WB_SEL: val = wb;
			default: val = rf;	// straight from the register file
		endcase
		return val;
	endfunction

	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;

	assign op1 = fwd_mux(fwd_rs1, rs1, ex_data, mem_data, wb_data);
	assign op2 = fwd_mux(fwd_rs2, rs2, ex_data, mem_data, wb_data);

	assign eq = (op1 == op2);
	assign lt = ($signed(op1) < $signed(op2));
	assign ltu = (op1 < op2);

	always_comb begin
		case (funct3)
			defines::BEQ: cond = eq;
			defines::BNE: cond = !eq;
			defines::BLT: cond = lt;
			defines::BGE: cond = !lt;
			defines::BLTU: cond = ltu;
			defines::BGEU: cond = !ltu;
			default: cond = 1'b0;	// 010 and 011 are no branch
		endcase
	end

	assign branch_taken = cond && (opcode == defines::B);

	// B and J offsets count in halfwords, I in bytes
	always_comb begin
		case (opcode)
			defines::B: imm = {{20{instr.imm.sign}}, instr.imm.b_11,
				instr.imm.imm_10_5, instr.imm.b_4_1, 1'b0};
			defines::JAL: imm = {{12{instr.imm.sign}}, instr.imm.imm_19_12,
				instr.imm.imm_20, instr.imm.imm_10_5, instr.imm.imm_4_1, 1'b0};
			defines::JALR: imm = {{21{instr.imm.sign}}, instr.imm.imm_10_5,
				instr.imm.imm_4_1, instr.imm.imm_20};
			default: imm = '0;
		endcase
	end

	// jalr is register relative, everything else pc relative
	assign base = (opcode == defines::JALR) ? op1 : pc;
	assign sum = base + imm;

	assign pc_bj = (opcode == defines::JALR) ? {sum[defines::XLEN-1:1], 1'b0} : sum;

	assign pc_sel = branch_taken
		|| (opcode == defines::JAL)
		|| (opcode == defines::JALR);

endmodule

/* src/pc_gen.sv */
module pc_gen (
	input logic clk,
	input logic rst_n,

	output logic imem_req,
	output defines::data_t imem_addr,
	input logic imem_ack,
	input defines::data_t imem_rdata,

	input defines::data_t pc_bj,
	input logic pc_sel,

	output defines::data_t pc,
	output defines::data_t pc_next,
	output defines::instr_t instr,
	output logic resolved
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,	// req high, waiting for ack
		WAIT_ACK_LOW,
		RESOLVE	// one cycle, pc takes pc_next
	} state_t;

	state_t state;
	state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: state_nxt = REQ;
			REQ: begin
				if (imem_ack)
					state_nxt = WAIT_ACK_LOW;
			end
			WAIT_ACK_LOW: begin
				// memory must finish its half of the handshake first
				if (!imem_ack)
					state_nxt = RESOLVE;
			end
			RESOLVE: state_nxt = REQ;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= defines::RESET_PC;
		else if (state == RESOLVE)
			pc <= pc_next;
	end

	// latch on the ack edge, held until the next fetch returns
	always_ff @(posedge clk) begin
		if (!rst_n)
			instr <= defines::NOP_WORD;
		else if (state == REQ && imem_ack)
			instr <= imem_rdata;
	end

	assign imem_req = (state == REQ);
	assign imem_addr = pc;	// pc only moves in RESOLVE, so stable during req
	assign resolved = (state == RESOLVE);

	assign pc_next = pc_sel ? pc_bj : pc + defines::PC_STEP;

endmodule

/* src/branch_stage.sv */
module branch_stage (
	input logic clk,
	input logic rst_n,

	// instruction memory, four-phase req/ack
	output logic imem_req,
	output defines::data_t imem_addr,
	input logic imem_ack,
	input defines::data_t imem_rdata,

	input defines::data_t rs1_data,
	input defines::data_t rs2_data,
	input defines::stage_src_t ex_src,
	input defines::stage_src_t mem_src,
	input defines::stage_src_t wb_src,

	output logic resolved,
	output defines::data_t pc,
	output defines::instr_t instr,
	output defines::data_t pc_next,
	output logic pc_sel,
	output logic branch_taken
);

	defines::branch_fwd_t fwd_rs1;
	defines::branch_fwd_t fwd_rs2;
	defines::data_t pc_bj;

	pc_gen u_pc_gen (
		.clk(clk),
		.rst_n(rst_n),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.imem_rdata(imem_rdata),
		.pc_bj(pc_bj),
		.pc_sel(pc_sel),
		.pc(pc),
		.pc_next(pc_next),
		.instr(instr),
		.resolved(resolved)
	);

	branch_fwd_unit u_branch_fwd_unit (
		.instr(instr),
		.ex_src(ex_src),
		.mem_src(mem_src),
		.wb_src(wb_src),
		.fwd_rs1(fwd_rs1),
		.fwd_rs2(fwd_rs2)
	);

	// only the data fields reach the operand mux
	pc_adder u_pc_adder (
		.instr(instr),
		.pc(pc),
		.rs1(rs1_data),
		.rs2(rs2_data),
		.ex_data(ex_src.data),
		.mem_data(mem_src.data),
		.wb_data(wb_src.data),
		.fwd_rs1(fwd_rs1),
		.fwd_rs2(fwd_rs2),
		.pc_bj(pc_bj),
		.pc_sel(pc_sel),
		.branch_taken(branch_taken)
	);

endmodule

/* tests/branch_stage_assertions.sv */
module branch_stage_assertions (
	input logic clk,
	input logic rst_n,
	input logic imem_req,
	input logic imem_ack,
	input defines::data_t imem_addr,
	input logic resolved
);

	timeunit 1ns;
	timeprecision 1ps;

	// once raised, req waits for the memory
	req_held: assert property (@(posedge clk) disable iff (!rst_n)
		imem_req && !imem_ack |=> imem_req)
		else $error("imem_req dropped before imem_ack");

	// previous handshake must be fully closed
	no_req_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(imem_req) |-> !imem_ack)
		else $error("imem_req rose while imem_ack was still high");

	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		imem_req |=> !imem_req || $stable(imem_addr))
		else $error("imem_addr changed during a request");

	resolved_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		resolved |=> !resolved)
		else $error("resolved held for more than one cycle");

	// only once the memory has dropped ack again
	resolved_idle: assert property (@(posedge clk) disable iff (!rst_n)
		resolved |-> !imem_req && !imem_ack && $past(!imem_ack))
		else $error("resolved before the fetch handshake was closed");

endmodule

bind pc_gen branch_stage_assertions u_branch_stage_assertions (
	.clk(clk),
	.rst_n(rst_n),
	.imem_req(imem_req),
	.imem_ack(imem_ack),
	.imem_addr(imem_addr),
	.resolved(resolved)
);

/* tests/tb_branch_stage.sv */
module tb_branch_stage;

	timeunit 1ns;
	timeprecision 1ps;

	localparam time CLK_PERIOD = 8ns;
	localparam int RESET_CYCLES = 16;
	localparam int ROW_CYCLES = 16;	// two 3 cycle ack delays plus the fsm overhead
	localparam logic [31:0] SEED = 32'h24375d3a;

	// one fetch: the word and everything the resolve cycle looks at
	typedef struct packed {
		defines::data_t word;
		defines::data_t rs1;
		defines::data_t rs2;
		defines::stage_src_t ex;
		defines::stage_src_t mem;
		defines::stage_src_t wb;
	} row_t;

	typedef struct packed {
		defines::branch_fwd_t fwd_rs1;
		defines::branch_fwd_t fwd_rs2;
		logic taken;
		logic sel;
		defines::data_t next;
	} expect_t;

	logic clk;
	logic rst_n;
	logic imem_req;
	defines::data_t imem_addr;
	logic imem_ack;
	defines::data_t imem_rdata;
	defines::data_t rs1_data;
	defines::data_t rs2_data;
	defines::stage_src_t ex_src;
	defines::stage_src_t mem_src;
	defines::stage_src_t wb_src;
	logic resolved;
	defines::data_t pc;
	defines::instr_t instr;
	defines::data_t pc_next;
	logic pc_sel;
	logic branch_taken;

	row_t rows[$];
	defines::data_t cur_word;	// what the memory answers with
	defines::data_t exp_pc;
	logic [31:0] rng_state;
	int resolve_count;
	logic table_done;

	branch_stage dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// RV32I encodings
	function automatic defines::data_t enc_b(
		input defines::funct3_t f3,
		input defines::reg_idx_t rs1,
		input defines::reg_idx_t rs2,
		input defines::data_t off
	);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], defines::B};
	endfunction

	function automatic defines::data_t enc_j(input defines::reg_idx_t rd, input defines::data_t off);
		return {off[20], off[10:1], off[11], off[19:12], rd, defines::JAL};
	endfunction

	function automatic defines::data_t enc_i(
		input defines::opcode_t opc,
		input defines::reg_idx_t rd,
		input defines::reg_idx_t rs1,
		input logic [11:0] imm
	);
		return {imm, rs1, 3'b000, rd, opc};
	endfunction

	function automatic defines::stage_src_t src(
		input logic we,
		input defines::reg_idx_t rd,
		input defines::data_t data
	);
		return {we, rd, data};
	endfunction

	task automatic add_row(
		input defines::data_t word,
		input defines::data_t a,
		input defines::data_t b,
		input defines::stage_src_t ex,
		input defines::stage_src_t mem,
		input defines::stage_src_t wb
	);
		row_t r;
		r = {word, a, b, ex, mem, wb};
		rows.push_back(r);
	endtask

	task automatic build_table();
		defines::funct3_t f3_list[6];
		defines::data_t a_vals[5];
		defines::data_t b_vals[5];
		defines::stage_src_t none;
		defines::data_t off;
		defines::data_t va;
		defines::data_t vb;
		defines::data_t vf;
		logic [31:0] rnd;
		f3_list = '{defines::BEQ, defines::BNE, defines::BLT,
			defines::BGE, defines::BLTU, defines::BGEU};
		// equal, less, greater, then two pairs where signed and unsigned disagree
		a_vals = '{32'd5, 32'd3, 32'd7, 32'hffff_fff0, 32'h0000_0010};
		b_vals = '{32'd5, 32'd7, 32'd3, 32'h0000_0010, 32'hffff_fff0};
		none = '0;
		add_row(enc_i(defines::OTHER, 5'd1, 5'd0, 12'h005), '0, '0, none, none, none);
		add_row(enc_i(defines::OTHER, 5'd2, 5'd1, 12'h800), '0, '0, none, none, none);
		foreach (f3_list[f]) begin
			for (int p = 0; p < 5; p++) begin
				off = p[0] ? 32'hffff_fff8 : 32'h0000_0010;
				add_row(enc_b(f3_list[f], 5'd1, 5'd2, off), a_vals[p], b_vals[p],
					none, none, none);
			end
		end
		add_row(enc_j(5'd1, 32'h0000_0800), '0, '0, none, none, none);
		add_row(enc_j(5'd1, 32'hffff_fff4), '0, '0, none, none, none);	// -12
		// odd sums, low bit must go
		add_row(enc_i(defines::JALR, 5'd1, 5'd3, 12'h010), 32'h1001, '0, none, none, none);
		add_row(enc_i(defines::JALR, 5'd1, 5'd3, 12'hffd), 32'h2000, '0, none, none, none);
		// EX beats MEM for rs1, WB alone supplies rs2
		add_row(enc_b(defines::BEQ, 5'd5, 5'd6, 32'h20), 32'd1, 32'd2,
			src(1'b1, 5'd5, 32'd7), src(1'b1, 5'd5, 32'd9), src(1'b1, 5'd6, 32'd7));
		// x0 writes and a disabled write are both ignored
		add_row(enc_b(defines::BNE, 5'd0, 5'd6, 32'h40), '0, '0,
			src(1'b1, 5'd0, 32'd5), src(1'b0, 5'd6, 32'd5), src(1'b1, 5'd0, 32'd5));
		add_row(enc_b(defines::BLT, 5'd7, 5'd8, 32'hffff_ffe0), 32'd5, '0,
			src(1'b1, 5'd9, 32'd1), src(1'b1, 5'd7, 32'h8000_0000), none);
		add_row(enc_i(defines::JALR, 5'd1, 5'd7, 12'h003), 32'h100, '0,
			src(1'b0, 5'd7, 32'h100), src(1'b1, 5'd7, 32'h4000), src(1'b1, 5'd7, 32'h9000));
		add_row(enc_i(defines::JALR, 5'd1, 5'd10, 12'h000), 32'h77, '0,
			none, none, src(1'b1, 5'd10, 32'h201));
		for (int k = 0; k < 8; k++) begin
			rnd = next_rand();
			va = next_rand();
			vb = rnd[0] ? va : next_rand();
			vf = next_rand();
			off = {{19{rnd[12]}}, rnd[12:1], 1'b0};
			add_row(enc_b(f3_list[rnd[15:13] % 6], {3'b0, rnd[17:16]} + 5'd1,
				{3'b0, rnd[19:18]} + 5'd1, off), va, vb,
				src(rnd[20], {2'b0, rnd[23:21]}, vf),
				src(rnd[24], {2'b0, rnd[27:25]}, vb),
				src(rnd[28], {2'b0, rnd[31:29]}, ~vf));
		end
		add_row(enc_i(defines::OTHER, 5'd3, 5'd3, 12'h001), '0, '0, none, none, none);
	endtask

	// reference model, straight from the RV32I rules
	function automatic defines::branch_fwd_t ref_fwd(input defines::reg_idx_t idx, input row_t r);
		if (idx == 5'd0)
			return defines::B_RS_SEL;
		if (r.ex.we && r.ex.rd == idx)
			return defines::B_EX_SEL;
		if (r.mem.we && r.mem.rd == idx)
			return defines::B_MEM_SEL;
		if (r.wb.we && r.wb.rd == idx)
			return defines::B_WB_SEL;
		return defines::B_RS_SEL;
	endfunction

	function automatic defines::data_t ref_operand(
		input defines::branch_fwd_t sel,
		input row_t r,
		input defines::data_t rf
	);
		case (sel)
			defines::B_EX_SEL: return r.ex.data;
			defines::B_MEM_SEL: return r.mem.data;
			defines::B_WB_SEL: return r.wb.data;
			default: return rf;
		endcase
	endfunction

	function automatic expect_t ref_resolve(input row_t r, input defines::data_t cur_pc);
		expect_t e;
		defines::instr_t w;
		defines::data_t wd;
		defines::data_t a;
		defines::data_t b;
		logic cond;
		w = r.word;
		wd = r.word;
		e.fwd_rs1 = ref_fwd(w.r.rs1, r);
		e.fwd_rs2 = ref_fwd(w.r.rs2, r);
		a = ref_operand(e.fwd_rs1, r, r.rs1);
		b = ref_operand(e.fwd_rs2, r, r.rs2);
		case (wd[14:12])
			3'b000: cond = (a == b);
			3'b001: cond = (a != b);
			3'b100: cond = ($signed(a) < $signed(b));
			3'b101: cond = ($signed(a) >= $signed(b));
			3'b110: cond = (a < b);
			3'b111: cond = (a >= b);
			default: cond = 1'b0;
		endcase
		e.taken = cond && (wd[6:0] == defines::B);
		e.sel = e.taken || (wd[6:0] == defines::JAL) || (wd[6:0] == defines::JALR);
		e.next = cur_pc + 32'd4;
		if (e.taken)
			e.next = cur_pc + {{20{wd[31]}}, wd[7], wd[30:25], wd[11:8], 1'b0};
		else if (wd[6:0] == defines::JAL)
			e.next = cur_pc + {{12{wd[31]}}, wd[19:12], wd[20], wd[30:21], 1'b0};
		else if (wd[6:0] == defines::JALR)
			e.next = (a + {{21{wd[31]}}, wd[30:20]}) & ~32'd1;
		return e;
	endfunction

	// instruction memory, four-phase with random ack delays
	always begin : imem_model
		int unsigned delay;
		@(negedge clk);
		if (imem_req === 1'b1) begin
			check("imem_addr", imem_addr, exp_pc);
			delay = next_rand() % 4;
			repeat (delay + 1) @(posedge clk);
			#1;
			imem_rdata = cur_word;
			imem_ack = 1'b1;
			do @(negedge clk); while (imem_req !== 1'b0);
			delay = next_rand() % 4;
			repeat (delay + 1) @(posedge clk);
			#1;
			imem_ack = 1'b0;
		end
	end

	always @(negedge clk) begin
		if (resolved === 1'b1)
			resolve_count = resolve_count + 1;
	end

	initial begin : stimulus
		expect_t e;
		row_t r;
		clk = 1'b0;
		rst_n = 1'b0;
		imem_ack = 1'b0;
		imem_rdata = '0;
		rs1_data = '0;
		rs2_data = '0;
		ex_src = '0;
		mem_src = '0;
		wb_src = '0;
		cur_word = defines::NOP_WORD;
		exp_pc = defines::RESET_PC;
		rng_state = SEED;
		resolve_count = 0;
		table_done = 1'b0;
		build_table();
		table_done = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		check("imem_req", imem_req, 1'b0);
		check("resolved", resolved, 1'b0);
		check("pc", pc, defines::RESET_PC);
		check("instr opcode", instr.r.opcode, 7'b0010011);
		rst_n = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			cur_word = r.word;
			rs1_data = r.rs1;
			rs2_data = r.rs2;
			ex_src = r.ex;
			mem_src = r.mem;
			wb_src = r.wb;
			do @(negedge clk); while (resolved !== 1'b1);
			e = ref_resolve(r, exp_pc);
			check("instr", instr, r.word);
			check("pc", pc, exp_pc);
			check("fwd_rs1", dut.fwd_rs1, e.fwd_rs1);
			check("fwd_rs2", dut.fwd_rs2, e.fwd_rs2);
			check("branch_taken", branch_taken, e.taken);
			check("pc_sel", pc_sel, e.sel);
			check("pc_next", pc_next, e.next);
			exp_pc = e.next;
			@(posedge clk);
			#1;
			check("resolve_count", resolve_count, i + 1);	// exactly one pulse per fetch
			check("resolved", resolved, 1'b0);
			check("pc", pc, exp_pc);
		end
		$display("Everything OK");
		$finish;
	end

	initial begin : watchdog
		int limit;
		wait (table_done === 1'b1);
		limit = RESET_CYCLES + rows.size() * ROW_CYCLES + 64;
		repeat (limit) @(posedge clk);
		$display("Timeout: the instructions did not all resolve within %0d cycles", limit);
		$display("Something failed");
		$fatal(1);
	end

endmodule

/* src.f */
src/defines.sv
src/branch_fwd_unit.sv
src/pc_adder.sv
src/pc_gen.sv
src/branch_stage.sv
tests/branch_stage_assertions.sv
tests/tb_branch_stage.sv

/* Bender.yml */
package:
  name: branch_stage

sources:
  - files:
      - src/defines.sv
      - src/branch_fwd_unit.sv
      - src/pc_adder.sv
      - src/pc_gen.sv
      - src/branch_stage.sv
  - target: test
    files:
      - tests/branch_stage_assertions.sv
      - tests/tb_branch_stage.sv
